// File: source/mont_pkg.sv
package mont_pkg;

    // one radix-4 digit
    localparam int digit_w = 2;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_add_b,    // sum += digit * b
        st_add_m,    // sum += q * m, then >> 2
        st_final,
        st_ack
    } mont_state_e;

    // accumulator commands
    typedef enum logic [2:0] {
        acc_hold,
        acc_clear,
        acc_add_b,
        acc_add_m_shift,
        acc_final_sub    // one conditional subtract, write result
    } acc_op_e;

    // command bundle from the FSM, 5 bits
    typedef struct packed {
        logic    load;    // capture operands, clear counter
        acc_op_e acc_op;
        logic    step;    // next a digit, count one iteration
    } mont_ctrl_t;

endpackage

// File: source/mont_ctrl_fsm.sv
`timescale 1ns/10ps

module mont_ctrl_fsm (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 req,
    input  logic                 last,
    output mont_pkg::mont_ctrl_t ctrl,
    output logic                 ack
);

    mont_pkg::mont_state_e state;
    mont_pkg::mont_state_e next_state;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            mont_pkg::st_idle: begin
                if (req) begin
                    next_state = mont_pkg::st_load;
                end
            end
            mont_pkg::st_load: begin
                next_state = mont_pkg::st_add_b;
            end
            mont_pkg::st_add_b: begin
                next_state = mont_pkg::st_add_m;
            end
            mont_pkg::st_add_m: begin
                // last digit done -> reduce once
                if (last) begin
                    next_state = mont_pkg::st_final;
                end else begin
                    next_state = mont_pkg::st_add_b;
                end
            end
            mont_pkg::st_final: begin
                next_state = mont_pkg::st_ack;
            end
            mont_pkg::st_ack: begin
                if (!req) begin
                    next_state = mont_pkg::st_idle; // handshake closes
                end
            end
            default: begin
                next_state = mont_pkg::st_idle;
            end
        endcase
    end

    // command decode, idle and ack leave everything at rest
    always_comb begin
        ctrl.load   = 1'b0;
        ctrl.acc_op = mont_pkg::acc_hold;
        ctrl.step   = 1'b0;
        case (state)
            mont_pkg::st_load: begin
                ctrl.load   = 1'b1;
                ctrl.acc_op = mont_pkg::acc_clear;
            end
            mont_pkg::st_add_b: begin
                ctrl.acc_op = mont_pkg::acc_add_b;
            end
            mont_pkg::st_add_m: begin
                ctrl.acc_op = mont_pkg::acc_add_m_shift;
                ctrl.step   = 1'b1;  // a digit and count move together
            end
            mont_pkg::st_final: begin
                ctrl.acc_op = mont_pkg::acc_final_sub;
            end
            default: begin
                ctrl.acc_op = mont_pkg::acc_hold;
            end
        endcase
    end

    assign ack = (state == mont_pkg::st_ack);

endmodule

// File: source/digit_counter.sv
`timescale 1ns/10ps

module digit_counter #(
    parameter int iterations = 16
) (
    input  logic clk,
    input  logic resetn,
    input  logic clear,
    input  logic step,
    output logic last
);

    // room for the count to reach iterations after the final step
    localparam int cnt_w = $clog2(iterations + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // high through the last add_m pass
    assign last = (cnt == cnt_w'(iterations - 1));

endmodule

// File: source/multiple_table.sv
`timescale 1ns/10ps

module multiple_table #(
    parameter int operand_w = 32
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          load,
    input  logic [operand_w-1:0]          b,
    input  logic [operand_w-1:0]          m,
    input  logic [mont_pkg::digit_w-1:0]  b_sel,
    input  logic [mont_pkg::digit_w-1:0]  m_sel,
    output logic [operand_w+1:0]          b_mult,
    output logic [operand_w+1:0]          m_mult,
    output logic [operand_w-1:0]          m_val
);

    logic [operand_w-1:0] b1_q, m1_q;
    logic [operand_w:0]   b2_q, m2_q;
    logic [operand_w+1:0] b3_q, m3_q;

    // 0/1x/2x/3x pick for one operand
    function automatic logic [operand_w+1:0] pick(
        input logic [mont_pkg::digit_w-1:0] sel,
        input logic [operand_w-1:0]         x1,
        input logic [operand_w:0]           x2,
        input logic [operand_w+1:0]         x3
    );
        logic [operand_w+1:0] y;
        case (sel)
            2'd1:    y = {2'b00, x1};
            2'd2:    y = {1'b0, x2};
            2'd3:    y = x3;
            default: y = '0;
        endcase
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b1_q <= '0;
            b2_q <= '0;
            b3_q <= '0;
            m1_q <= '0;
            m2_q <= '0;
            m3_q <= '0;
        end else if (load) begin
            b1_q <= b;
            b2_q <= {b, 1'b0};
            b3_q <= {2'b00, b} + {1'b0, b, 1'b0}; // 3b = b + 2b
            m1_q <= m;
            m2_q <= {m, 1'b0};
            m3_q <= {2'b00, m} + {1'b0, m, 1'b0};
        end
    end

    assign b_mult = pick(b_sel, b1_q, b2_q, b3_q);
    assign m_mult = pick(m_sel, m1_q, m2_q, m3_q);
    assign m_val  = m1_q;

endmodule

// File: source/a_digit_shifter.sv
`timescale 1ns/10ps

module a_digit_shifter #(
    parameter int operand_w = 32
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         load,
    input  logic                         step,
    input  logic [operand_w-1:0]         a,
    output logic [mont_pkg::digit_w-1:0] a_digit
);

    logic [operand_w-1:0] a_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
        end else if (load) begin
            a_q <= a;
        end else if (step) begin
            // zeros fill from the top, used digits drop out
            a_q <= a_q >> mont_pkg::digit_w;
        end
    end

    assign a_digit = a_q[mont_pkg::digit_w-1:0]; // current radix-4 digit

endmodule

// File: source/mont_accumulator.sv
`timescale 1ns/10ps

module mont_accumulator #(
    parameter int operand_w = 32
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  mont_pkg::acc_op_e             acc_op,
    input  logic [operand_w+1:0]          b_mult,
    input  logic [operand_w+1:0]          m_mult,
    input  logic [operand_w-1:0]          m_val,
    output logic [mont_pkg::digit_w-1:0]  q_digit,
    output logic [operand_w-1:0]          result
);

    // sum stays below 2m between passes, peak is under 8m
    localparam int sum_w = operand_w + 3;

    logic [sum_w-1:0]              sum_q;
    logic [sum_w-1:0]              sum_b;
    logic [sum_w-1:0]              sum_m;
    logic [sum_w:0]                diff;   // msb is the borrow
    logic [mont_pkg::digit_w-1:0]  neg_low;
    logic [operand_w-1:0]          result_q;

    assign sum_b = sum_q + {1'b0, b_mult};
    assign sum_m = sum_q + {1'b0, m_mult};
    assign diff  = {1'b0, sum_q} - {4'b0000, m_val};

    // m odd, so m is its own inverse mod 4
    // q = -sum * m mod 4 clears the two low bits of sum + q*m
    assign neg_low = ~sum_q[mont_pkg::digit_w-1:0] + 1'b1;
    always_comb begin
        q_digit = mont_pkg::digit_w'(neg_low * m_val[mont_pkg::digit_w-1:0]);
    end

    always_ff @(posedge clk) begin
        case (acc_op)
            mont_pkg::acc_clear: begin
                sum_q <= '0;
            end
            mont_pkg::acc_add_b: begin
                sum_q <= sum_b;
            end
            mont_pkg::acc_add_m_shift: begin
                sum_q <= sum_m >> mont_pkg::digit_w; // exact divide by 4
            end
            default: begin
                sum_q <= sum_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_q <= '0;
        end else if (acc_op == mont_pkg::acc_final_sub) begin
            if (diff[sum_w]) begin
                result_q <= sum_q[operand_w-1:0]; // already below m
            end else begin
                result_q <= diff[operand_w-1:0];
            end
        end
    end

    assign result = result_q;

endmodule

// File: source/mont_mult.sv
`timescale 1ns/10ps

module mont_mult #(
    parameter int operand_w = 32
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 req,
    input  logic [operand_w-1:0] a,
    input  logic [operand_w-1:0] b,
    input  logic [operand_w-1:0] m,
    output logic                 ack,
    output logic [operand_w-1:0] result
);

    localparam int iterations = operand_w / 2; // radix-4, two bits per pass

    mont_pkg::mont_ctrl_t              ctrl;
    logic                              last;
    logic [mont_pkg::digit_w-1:0]      a_digit;
    logic [mont_pkg::digit_w-1:0]      q_digit;
    logic [operand_w+1:0]              b_mult;
    logic [operand_w+1:0]              m_mult;
    logic [operand_w-1:0]              m_val;

    mont_ctrl_fsm i_mont_ctrl_fsm (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .last   (last),
        .ctrl   (ctrl),
        .ack    (ack)
    );

    digit_counter #(.iterations(iterations)) i_digit_counter (
        .clk    (clk),
        .resetn (resetn),
        .clear  (ctrl.load),
        .step   (ctrl.step),
        .last   (last)
    );

    // b multiple picked by the a digit, m multiple by the reduction digit
    multiple_table #(.operand_w(operand_w)) i_multiple_table (
        .clk    (clk),
        .resetn (resetn),
        .load   (ctrl.load),
        .b      (b),
        .m      (m),
        .b_sel  (a_digit),
        .m_sel  (q_digit),
        .b_mult (b_mult),
        .m_mult (m_mult),
        .m_val  (m_val)
    );

    a_digit_shifter #(.operand_w(operand_w)) i_a_digit_shifter (
        .clk     (clk),
        .resetn  (resetn),
        .load    (ctrl.load),
        .step    (ctrl.step),
        .a       (a),
        .a_digit (a_digit)
    );

    mont_accumulator #(.operand_w(operand_w)) i_mont_accumulator (
        .clk     (clk),
        .resetn  (resetn),
        .acc_op  (ctrl.acc_op),
        .b_mult  (b_mult),
        .m_mult  (m_mult),
        .m_val   (m_val),
        .q_digit (q_digit),
        .result  (result)
    );

endmodule

// File: verif/mont_mult_sva.sv
`timescale 1ns/10ps

module mont_mult_sva #(
    parameter int operand_w = 32
) (
    input logic                 clk,
    input logic                 resetn,
    input logic                 req,
    input logic                 ack,
    input logic [operand_w-1:0] result
);

    int fail_cnt = 0; // assertion failures so far

    // ack only answers a live request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(ack) |-> req
    ) else begin
        fail_cnt++;
        $error("ack rose while req was low");
    end

    // result held for the whole ack phase
    result_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        ack |=> $stable(result)
    ) else begin
        fail_cnt++;
        $error("result changed while ack was high");
    end

    ack_follows_req: assert property (
        @(posedge clk) disable iff (!resetn)
        $fell(req) |-> ##[0:1] !ack
    ) else begin
        fail_cnt++;
        $error("ack did not fall within one cycle of req falling");
    end

endmodule

bind mont_mult mont_mult_sva #(.operand_w(operand_w)) i_mont_mult_sva (
    .clk    (clk),
    .resetn (resetn),
    .req    (req),
    .ack    (ack),
    .result (result)
);

// File: verif/tb_mont_mult.sv
`timescale 1ns/10ps

module tb_mont_mult;

    localparam int operand_w = 32;
    localparam int latency_exp = operand_w + 2;
    localparam int max_wait = 60;
    localparam int n_trans = 26;   // 3 directed, 20 random, 1 latency, 2 back-pressure
    localparam int wd_cycles = n_trans * max_wait + 200;

    logic                 clk;
    logic                 resetn;
    logic                 req;
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
    logic [operand_w-1:0] m;
    logic                 ack;
    logic [operand_w-1:0] result;

    integer seed;
    int     errors;
    int     checks;

    mont_mult #(.operand_w(operand_w)) i_mont_mult (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .a      (a),
        .b      (b),
        .m      (m),
        .ack    (ack),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // result*2^32 == a*b (mod m), and result < m
    task automatic check_product(input logic [31:0] op_a, input logic [31:0] op_b,
                                 input logic [31:0] op_m, input logic [31:0] res);
        logic [127:0] lhs;
        logic [127:0] rhs;
        lhs = ({96'd0, res} << 32) % {96'd0, op_m};
        rhs = ({96'd0, op_a} * {96'd0, op_b}) % {96'd0, op_m};
        check("result < m", res < op_m, 1'b1);
        check("result residue", lhs, rhs);
    endtask

    // one req/ack cycle, req held for hold extra cycles after ack
    task automatic run_transaction(input logic [31:0] op_a, input logic [31:0] op_b,
                                   input logic [31:0] op_m, input int hold,
                                   output int latency);
        logic        got_ack;
        logic [31:0] held;
        int          n;
        got_ack = 1'b0;
        latency = 0;
        @(posedge clk);
        req <= 1'b1;
        a   <= op_a;
        b   <= op_b;
        m   <= op_m;
        @(posedge clk);  // edge 0, req sampled
        while (!got_ack && latency <= max_wait) begin
            @(negedge clk);
            if (ack) begin
                got_ack = 1'b1;
            end else begin
                @(posedge clk);
                latency++;
            end
        end
        if (!got_ack) begin
            errors++;
            $display("no ack from the DUT within %0d cycles of the request", max_wait);
        end else begin
            check_product(op_a, op_b, op_m, result);
            held = result;
            repeat (hold) begin
                @(negedge clk);
                check("ack", ack, 1'b1);
                check("result", result, held);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ack && n < 3);
        check("ack", ack, 1'b0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished, %0d errors", name, errors - errors_before);
    endtask

    task automatic after_reset;
        int e0;
        e0 = errors;
        @(negedge clk);
        check("ack", ack, 1'b0);
        check("result", result, 0);
        report_test("after_reset", e0);
    endtask

    task automatic directed_operands;
        int e0;
        int lat;
        e0 = errors;
        run_transaction(32'd1, 32'd1, 32'd3, 0, lat);
        run_transaction(32'd0, 32'hffff_fffe, 32'hffff_ffff, 0, lat);
        run_transaction(32'd12, 32'd12, 32'd13, 0, lat);  // a = b = m-1
        report_test("directed", e0);
    endtask

    task automatic random_operands;
        int          e0;
        int          lat;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rm;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            rm = $random(seed);
            rm[0] = 1'b1;  // modulus must be odd
            ra = $random(seed);
            rb = $random(seed);
            run_transaction(ra % rm, rb % rm, rm, 0, lat);
        end
        report_test("random", e0);
    endtask

    task automatic ack_latency;
        int e0;
        int lat;
        e0 = errors;
        run_transaction(32'h0bad_cafe, 32'h1234_5678, 32'hdead_beef, 0, lat);
        check("ack latency", lat, latency_exp);
        report_test("latency", e0);
    endtask

    task automatic back_pressure;
        int e0;
        int lat;
        e0 = errors;
        run_transaction(32'h89ab_cdef, 32'h7654_3210, 32'hffff_fffb, 20, lat);
        run_transaction(32'h7fff_fffe, 32'h1234_5679, 32'h8000_0001, 0, lat);  // back to back
        check("ack latency", lat, latency_exp);
        report_test("backpressure", e0);
    endtask

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the DUT did not finish all transactions in %0d cycles", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed   = 32'h1ee9a751;
        errors = 0;
        checks = 0;
        resetn = 1'b0;
        req    = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        after_reset();
        directed_operands();
        random_operands();
        ack_latency();
        back_pressure();
        errors += i_mont_mult.i_mont_mult_sva.fail_cnt; // failed assertions count too
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: mont_mult.f
source/mont_pkg.sv
source/mont_ctrl_fsm.sv
source/digit_counter.sv
source/multiple_table.sv
source/a_digit_shifter.sv
source/mont_accumulator.sv
source/mont_mult.sv
verif/mont_mult_sva.sv
verif/tb_mont_mult.sv
